// ==== tests/corHStimulus.txt ====
// Per case 88 hex words: 40 h samples, 40 expected scaled h, 8 expected rr (lag 0..7)
// Samples are sign-extended 32-bit words, h lines hold 10 words, the rr line 8
// Case 0: low energy, norm count 13, shift left by 6
00000100 ffffff80 00000040 ffffffe0 00000010 fffffff8 00000004 fffffffe 00000001 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00004000 ffffe000 00001000 fffff800 00000400 fffffe00 00000100 ffffff80 00000040 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
2aaaa000 eaaac000 0aaa8000 faab0000 02aa0000 feac0000 00a80000 ffb00000
// Case 1: energy saturates above the limit, every sample halved
00007000 ffffc800 00001c00 fffff200 00000700 fffffc80 000001c0 ffffff20 00000070 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00003800 ffffe400 00000e00 fffff900 00000380 fffffe40 000000e0 ffffff90 00000038 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
20aaa280 efaabb00 082a8a00 fbeaec00 020a2800 fefbb000 0080a000 ffc2c000
// Case 2: full-scale alternating h, halved, rr saturates at both limits
00007fff ffff8001 00007fff ffff8001 00007fff ffff8001 00007fff ffff8001 00007fff ffff8001
00007fff ffff8001 00007fff ffff8001 00007fff ffff8001 00007fff ffff8001 00007fff ffff8001
00007fff ffff8001 00007fff ffff8001 00007fff ffff8001 00007fff ffff8001 00007fff ffff8001
00007fff ffff8001 00007fff ffff8001 00007fff ffff8001 00007fff ffff8001 00007fff ffff8001
00003fff ffffc000 00003fff ffffc000 00003fff ffffc000 00003fff ffffc000 00003fff ffffc000
00003fff ffffc000 00003fff ffffc000 00003fff ffffc000 00003fff ffffc000 00003fff ffffc000
00003fff ffffc000 00003fff ffffc000 00003fff ffffc000 00003fff ffffc000 00003fff ffffc000
00003fff ffffc000 00003fff ffffc000 00003fff ffffc000 00003fff ffffc000 00003fff ffffc000
7fffffff 80000000 7fffffff 80000000 7fffffff 80000000 7fffffff 80000000
// Case 3: all-zero h
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
// Case 4: two small taps, norm count 26, shift left by 13
fffffffd 00000000 00000000 00000002 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
ffffa000 00000000 00000000 00004000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
68000000 00000000 00000000 d0000000 00000000 00000000 00000000 00000000

// ==== corHPipe.f ====
design/g729TypesPkg.sv
design/corHMapPkg.sv
design/satAdd.sv
design/lMac.sv
design/normL.sv
design/scratchMemory.sv
design/corHSequencer.sv
design/corHPipe.sv
tests/corHPipeTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the Cor_h testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1
LOG=runSim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module corHPipeTb \
	-f corHPipe.f -o corHPipeSim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/corHPipeSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "test passed" "$LOG"; then
	exit 0
fi
exit 1

// ==== tests/corHPipeTb.sv ====
`timescale 1ns/100ps

module corHPipeTb;

	localparam int NUM_CASES = 5;
	localparam int CASE_WORDS = 2 * corHMapPkg::L_SUBFR + corHMapPkg::NUM_LAGS;
	localparam int WATCHDOG_CYCLES = NUM_CASES * 6000;

	// Energy, compare, norm and scale take fewer cycles than this
	localparam int BUSY_START_CYCLES = 4 * corHMapPkg::L_SUBFR;

	logic clk = 1'b0;
	logic rstN;
	logic start;
	logic corHMuxSel;
	logic [corHMapPkg::ADDR_W-1:0] testReadAddr;
	logic [corHMapPkg::ADDR_W-1:0] testWriteAddr;
	g729TypesPkg::word32T testMemOut;
	logic testMemWriteEn;
	logic done;
	g729TypesPkg::word32T memIn;

	// Per case h, expected scaled h and expected rr
	logic [31:0] stimMem [NUM_CASES*CASE_WORDS];
	int errorCount;
	int checkCount;
	int doneCount;
	logic startSeen;
	integer seed;

	corHPipe dut0 (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.corHMuxSel(corHMuxSel),
		.testReadAddr(testReadAddr),
		.testWriteAddr(testWriteAddr),
		.testMemOut(testMemOut),
		.testMemWriteEn(testMemWriteEn),
		.done(done),
		.memIn(memIn)
	);

	initial
	begin
		forever #50 clk = ~clk;
	end

	// Counts done pulses and flags any before the first start
	always @(negedge clk)
	begin
		if (done)
		begin
			doneCount++;
			assert (startSeen)
			else
			begin
				errorCount++;
				$display("[ERROR] %0t ns: done pulsed before the first start", $time);
			end
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("test failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Test port access from a falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic writeWord(input int addr, input logic [31:0] data);
		testWriteAddr = corHMapPkg::addrT'(addr);
		testMemOut = data;
		testMemWriteEn = 1'b1;
		@(negedge clk);
		testMemWriteEn = 1'b0;
	endtask

	// Read data arrives one edge after the address
	task automatic readWord(input int addr, output logic [31:0] data);
		testReadAddr = corHMapPkg::addrT'(addr);
		@(negedge clk);
		data = memIn;
	endtask

	task automatic checkWord(input int caseIdx, input int addr, input logic [31:0] expected,
		input string what);
		logic [31:0] got;
		readWord(addr, got);
		checkCount++;
		assert (got === expected)
		else
		begin
			errorCount++;
			$display("[ERROR] %0t ns: case %0d %s at address %0d read %h, expected %h",
				$time, caseIdx, what, addr, got, expected);
		end
	endtask

	function automatic logic [31:0] probePattern(input int addr);
		logic [corHMapPkg::ADDR_W-1:0] a;
		a = corHMapPkg::addrT'(addr);
		return {5'h15, a, 5'h0a, ~a};
	endfunction

	// Write then read back a few spread addresses
	task automatic probeTestPort();
		int addrs [4];
		addrs = '{100, 513, 1024, corHMapPkg::MEM_DEPTH - 1};
		corHMuxSel = 1'b1;
		foreach (addrs[i])
		begin
			writeWord(addrs[i], probePattern(addrs[i]));
			checkWord(-1, addrs[i], probePattern(addrs[i]), "test port word");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// One case from the stimulus file
	//////////////////////////////////////////////////////////////////////

	task automatic runCase(input int caseIdx);
		int base;
		int gap;
		int doneBefore;
		base = caseIdx * CASE_WORDS;
		corHMuxSel = 1'b1;
		for (int n = 0; n < corHMapPkg::L_SUBFR; n++)
			writeWord(corHMapPkg::H_BASE + n, stimMem[base + n]);
		corHMuxSel = 1'b0;

		gap = $random(seed) & 7;
		repeat (gap) @(negedge clk);
		doneBefore = doneCount;
		start = 1'b1;
		startSeen = 1'b1;
		@(negedge clk);
		start = 1'b0;

		// Extra start during the correlation, after h was rewritten
		repeat (BUSY_START_CYCLES) @(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;

		while (!done)
			@(negedge clk);
		repeat (5) @(negedge clk);
		checkCount++;
		assert (doneCount - doneBefore == 1)
		else
		begin
			errorCount++;
			$display("[ERROR] %0t ns: case %0d gave %0d done pulses, expected 1",
				$time, caseIdx, doneCount - doneBefore);
		end

		corHMuxSel = 1'b1;
		for (int n = 0; n < corHMapPkg::L_SUBFR; n++)
			checkWord(caseIdx, corHMapPkg::H_BASE + n,
				stimMem[base + corHMapPkg::L_SUBFR + n], "scaled h");
		for (int k = 0; k < corHMapPkg::NUM_LAGS; k++)
			checkWord(caseIdx, corHMapPkg::RR_BASE + k,
				stimMem[base + 2 * corHMapPkg::L_SUBFR + k], "rr");
	endtask

	initial
	begin
		seed = 32'h6cef;
		errorCount = 0;
		checkCount = 0;
		doneCount = 0;
		startSeen = 1'b0;
		rstN = 1'b0;
		start = 1'b0;
		corHMuxSel = 1'b0;
		testReadAddr = '0;
		testWriteAddr = '0;
		testMemOut = '0;
		testMemWriteEn = 1'b0;
		$readmemh("tests/corHStimulus.txt", stimMem);

		repeat (10) @(negedge clk);
		rstN = 1'b1;
		repeat (4) @(negedge clk);

		probeTestPort();
		for (int c = 0; c < NUM_CASES; c++)
			runCase(c);

		$display("Closing: %0d checks, %0d errors, %0d done pulses",
			checkCount, errorCount, doneCount);
		if (errorCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== design/corHPipe.sv ====
`timescale 1ns/100ps

module corHPipe (
	input logic clk,
	input logic rstN,
	input logic start,
	input logic corHMuxSel,
	input logic [corHMapPkg::ADDR_W-1:0] testReadAddr,
	input logic [corHMapPkg::ADDR_W-1:0] testWriteAddr,
	input g729TypesPkg::word32T testMemOut,
	input logic testMemWriteEn,
	output logic done,
	output g729TypesPkg::word32T memIn
);

	logic [corHMapPkg::ADDR_W-1:0] memReadAddr, memWriteAddr;
	logic [corHMapPkg::ADDR_W-1:0] muxReadAddr, muxWriteAddr;
	g729TypesPkg::word32T memOut, muxWriteData;
	logic memWriteEn, muxWriteEn;

	g729TypesPkg::word16T macA, macB;
	g729TypesPkg::word32T macC, macOut;
	g729TypesPkg::word32T addA, addB, addSum;
	g729TypesPkg::word16T idxA, idxB, idxSum;
	g729TypesPkg::word32T normIn;
	g729TypesPkg::word16T normCount;
	logic normReady, normDone;
	logic running;

	//////////////////////////////////////////////////////////////////////
	// Memory, sequencer and basic operators
	//////////////////////////////////////////////////////////////////////

	scratchMemory corHMem (
		.clk(clk),
		.writeAddr(muxWriteAddr),
		.readAddr(muxReadAddr),
		.writeData(muxWriteData),
		.writeEn(muxWriteEn),
		.readData(memIn)
	);

	corHSequencer corHFsm (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.memIn(memIn),
		.memReadAddr(memReadAddr),
		.memWriteAddr(memWriteAddr),
		.memOut(memOut),
		.memWriteEn(memWriteEn),
		.macA(macA),
		.macB(macB),
		.macC(macC),
		.macOut(macOut),
		.addA(addA),
		.addB(addB),
		.addSum(addSum),
		.idxA(idxA),
		.idxB(idxB),
		.idxSum(idxSum),
		.normIn(normIn),
		.normReady(normReady),
		.normCount(normCount),
		.normDone(normDone),
		.done(done)
	);

	lMac corHLMac (
		.a(macA),
		.b(macB),
		.c(macC),
		.out(macOut)
	);

	// Threshold compare as L_sub
	satAdd #(.wordT(g729TypesPkg::word32T)) corHLSub (
		.a(addA),
		.b(addB),
		.subtract(1'b1),
		.sum(addSum)
	);

	// Sample and lag stepping
	satAdd #(.wordT(g729TypesPkg::word16T)) corHIdxAdd (
		.a(idxA),
		.b(idxB),
		.subtract(1'b0),
		.sum(idxSum)
	);

	normL corHNormL (
		.clk(clk),
		.rstN(rstN),
		.normIn(normIn),
		.ready(normReady),
		.normCount(normCount),
		.done(normDone)
	);

	// Test port takes the memory when selected
	always_comb
	begin
		if (corHMuxSel)
		begin
			muxReadAddr = testReadAddr;
			muxWriteAddr = testWriteAddr;
			muxWriteData = testMemOut;
			muxWriteEn = testMemWriteEn;
		end
		else
		begin
			muxReadAddr = memReadAddr;
			muxWriteAddr = memWriteAddr;
			muxWriteData = memOut;
			muxWriteEn = memWriteEn;
		end
	end

	// Start to done window
	always_ff @(posedge clk)
	begin
		if (!rstN)
			running <= 1'b0;
		else if (start)
			running <= 1'b1;
		else if (done)
			running <= 1'b0;
	end

	muxWriteOwner: assert property (@(posedge clk) disable iff (!rstN)
		!corHMuxSel |-> !testMemWriteEn)
		else $error("test write enable raised while the sequencer owns memory");

	muxHeldLow: assert property (@(posedge clk) disable iff (!rstN)
		running |-> !corHMuxSel)
		else $error("test port selected between start and done");

endmodule

// ==== design/corHSequencer.sv ====
`timescale 1ns/100ps

module corHSequencer (
	input logic clk,
	input logic rstN,
	input logic start,
	input g729TypesPkg::word32T memIn,
	output logic [corHMapPkg::ADDR_W-1:0] memReadAddr,
	output logic [corHMapPkg::ADDR_W-1:0] memWriteAddr,
	output g729TypesPkg::word32T memOut,
	output logic memWriteEn,
	output g729TypesPkg::word16T macA,
	output g729TypesPkg::word16T macB,
	output g729TypesPkg::word32T macC,
	input g729TypesPkg::word32T macOut,
	output g729TypesPkg::word32T addA,
	output g729TypesPkg::word32T addB,
	input g729TypesPkg::word32T addSum,
	output g729TypesPkg::word16T idxA,
	output g729TypesPkg::word16T idxB,
	input g729TypesPkg::word16T idxSum,
	output g729TypesPkg::word32T normIn,
	output logic normReady,
	input g729TypesPkg::word16T normCount,
	input logic normDone,
	output logic done
);

	typedef enum logic [2:0] {
		stIdle,
		stEnergy,
		stCompare,
		stNorm,
		stScale,
		stCorr,
		stWriteRr
	} stateT;

	stateT state;
	g729TypesPkg::word16T rdIdx;
	g729TypesPkg::word16T lag;
	logic second;
	logic scaleRight;
	logic [3:0] shiftAmt;

	g729TypesPkg::word32T acc;
	g729TypesPkg::word16T heldA;
	g729TypesPkg::word16T sample;
	g729TypesPkg::word16T scaled;
	g729TypesPkg::word32T shifted;

	//////////////////////////////////////////////////////////////////////
	// Operator and memory hookup
	//////////////////////////////////////////////////////////////////////

	assign sample = memIn[15:0];

	// Energy squares the sample, correlation pairs it with the held one
	assign macA = (state == stCorr) ? heldA : sample;
	assign macB = sample;
	assign macC = acc;

	// extract_h(energy) - SCALE_LIMIT
	assign addA = acc >>> 16;
	assign addB = g729TypesPkg::word32T'(corHMapPkg::SCALE_LIMIT);

	assign idxA = (state == stWriteRr) ? lag : rdIdx;
	assign idxB = 16'sd1;

	assign normIn = acc;

	// shr by 1, or shl by half the norm count
	always_comb
	begin
		shifted = g729TypesPkg::word32T'(sample) <<< shiftAmt;
		if (scaleRight)
			scaled = sample >>> 1;
		else if (shifted > g729TypesPkg::MAX16)
			scaled = g729TypesPkg::MAX16;
		else if (shifted < g729TypesPkg::MIN16)
			scaled = g729TypesPkg::MIN16;
		else
			scaled = shifted[15:0];
	end

	always_comb
	begin
		// Second read of a pair fetches hs[n+lag]
		if (state == stCorr && second)
			memReadAddr = corHMapPkg::addrT'(corHMapPkg::H_BASE + rdIdx + lag);
		else
			memReadAddr = corHMapPkg::addrT'(corHMapPkg::H_BASE + rdIdx);

		// Scaled sample goes back one behind the read
		if (state == stWriteRr)
			memWriteAddr = corHMapPkg::addrT'(corHMapPkg::RR_BASE + lag);
		else
			memWriteAddr = corHMapPkg::addrT'(corHMapPkg::H_BASE + rdIdx - 1);
	end

	assign memWriteEn = (state == stScale && rdIdx != 0) || state == stWriteRr;
	assign memOut = (state == stScale) ? g729TypesPkg::word32T'(scaled) : acc;

	//////////////////////////////////////////////////////////////////////
	// Datapath registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		case (state)
			stIdle:
				acc <= g729TypesPkg::word32T'(corHMapPkg::ENERGY_SEED);
			stEnergy, stCorr:
				if (rdIdx != 0 && !second)
					acc <= macOut;
			stScale, stWriteRr:
				acc <= '0;
			default:
				acc <= acc;
		endcase
		if (state == stCorr && second)
			heldA <= sample;
	end

	//////////////////////////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= stIdle;
			rdIdx <= '0;
			lag <= '0;
			second <= 1'b0;
			scaleRight <= 1'b0;
			shiftAmt <= '0;
			normReady <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			normReady <= 1'b0;
			done <= 1'b0;
			case (state)
				stIdle:
					if (start)
					begin
						rdIdx <= '0;
						state <= stEnergy;
					end
				stEnergy:
					// Last sample lands the cycle after its read
					if (rdIdx == corHMapPkg::L_SUBFR)
					begin
						rdIdx <= '0;
						state <= stCompare;
					end
					else
						rdIdx <= idxSum;
				stCompare:
				begin
					scaleRight <= (addSum > 0);
					if (addSum > 0)
						state <= stScale;
					else
					begin
						normReady <= 1'b1;
						state <= stNorm;
					end
				end
				stNorm:
					if (normDone)
					begin
						shiftAmt <= normCount[4:1];
						state <= stScale;
					end
				stScale:
					if (rdIdx == corHMapPkg::L_SUBFR)
					begin
						rdIdx <= '0;
						lag <= '0;
						second <= 1'b0;
						state <= stCorr;
					end
					else
						rdIdx <= idxSum;
				stCorr:
					if (!second)
					begin
						if (rdIdx == corHMapPkg::L_SUBFR - lag)
							state <= stWriteRr;
						else
							second <= 1'b1;
					end
					else
					begin
						rdIdx <= idxSum;
						second <= 1'b0;
					end
				stWriteRr:
				begin
					lag <= idxSum;
					rdIdx <= '0;
					if (lag == corHMapPkg::NUM_LAGS - 1)
					begin
						done <= 1'b1;
						state <= stIdle;
					end
					else
						state <= stCorr;
				end
				default:
					state <= stIdle;
			endcase
		end
	end

endmodule

// ==== design/scratchMemory.sv ====
`timescale 1ns/100ps

module scratchMemory (
	input logic clk,
	input logic [corHMapPkg::ADDR_W-1:0] writeAddr,
	input logic [corHMapPkg::ADDR_W-1:0] readAddr,
	input g729TypesPkg::word32T writeData,
	input logic writeEn,
	output g729TypesPkg::word32T readData
);

	g729TypesPkg::word32T mem [corHMapPkg::MEM_DEPTH];

	// Write port
	always_ff @(posedge clk)
	begin
		if (writeEn)
			mem[writeAddr] <= writeData;
	end

	// Registered read, old data on a same-address write
	always_ff @(posedge clk)
	begin
		readData <= mem[readAddr];
	end

endmodule

// ==== design/normL.sv ====
`timescale 1ns/100ps

module normL (
	input logic clk,
	input logic rstN,
	input g729TypesPkg::word32T normIn,
	input logic ready,
	output g729TypesPkg::word16T normCount,
	output logic done
);

	g729TypesPkg::word32T value;
	logic busy;

	// Working copy, shifted once per busy cycle
	always_ff @(posedge clk)
	begin
		if (ready && !busy)
			value <= normIn;
		else if (busy)
			value <= value <<< 1;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			normCount <= '0;
		end
		else
		begin
			done <= 1'b0;
			if (busy)
			begin
				normCount <= normCount + 16'sd1;
				// Next value has bit 30 apart from the sign
				if (value[29] != value[30])
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
			else if (ready)
			begin
				normCount <= '0;
				// Zero or already normalized finishes at once
				if (normIn == 0 || normIn[30] != normIn[31])
					done <= 1'b1;
				else
					busy <= 1'b1;
			end
		end
	end

	// Sequencer waits for done before a new request
	readyWhileBusy: assert property (@(posedge clk) disable iff (!rstN) busy |-> !ready)
		else $error("normL ready raised during a count");

endmodule

// ==== design/lMac.sv ====
`timescale 1ns/100ps

module lMac (
	input g729TypesPkg::word16T a,
	input g729TypesPkg::word16T b,
	input g729TypesPkg::word32T c,
	output g729TypesPkg::word32T out
);

	g729TypesPkg::word32T product;
	g729TypesPkg::word32T doubled;

	// Extra bit for the accumulate
	logic [32:0] total;

	always_comb
	begin
		// Plain 16x16 signed product
		product = a * b;

		// L_mult, only 0x8000 * 0x8000 overflows once doubled
		if (product == 32'sh4000_0000)
			doubled = g729TypesPkg::MAX32;
		else
			doubled = product <<< 1;

		// L_add of the accumulator
		total = {c[31], c} + {doubled[31], doubled};

		if (total[32] != total[31])
		begin
			if (total[32])
				out = g729TypesPkg::MIN32;
			else
				out = g729TypesPkg::MAX32;
		end
		else
			out = total[31:0];
	end

endmodule

// ==== design/satAdd.sv ====
`timescale 1ns/100ps

module satAdd #(
	parameter type wordT = g729TypesPkg::word32T
) (
	input wordT a,
	input wordT b,
	input logic subtract,
	output wordT sum
);

	localparam int W = $bits(wordT);

	// One guard bit above the word
	logic [W:0] wide;

	always_comb
	begin
		if (subtract)
			wide = {a[W-1], a} - {b[W-1], b};
		else
			wide = {a[W-1], a} + {b[W-1], b};

		// Guard and sign disagree on overflow
		if (wide[W] != wide[W-1])
		begin
			if (wide[W])
				sum = {1'b1, {(W-1){1'b0}}};
			else
				sum = {1'b0, {(W-1){1'b1}}};
		end
		else
			sum = wide[W-1:0];
	end

endmodule

// ==== design/corHMapPkg.sv ====
package corHMapPkg;

	// Scratch memory geometry
	localparam int ADDR_W = 11;
	localparam int MEM_DEPTH = 2048;

	typedef logic [ADDR_W-1:0] addrT;

	// Subframe length and number of autocorrelation terms
	localparam int L_SUBFR = 40;
	localparam int NUM_LAGS = 8;

	// h[0..39] at the bottom, rr words further up
	localparam int H_BASE = 0;
	localparam int RR_BASE = 64;

	// High word of the energy above this halves h
	localparam int SCALE_LIMIT = 32000;

	// Energy accumulator starts here rather than at zero
	localparam int ENERGY_SEED = 2;

endpackage

// ==== design/g729TypesPkg.sv ====
package g729TypesPkg;

	//////////////////////////////////////////////////////////////////////
	// Word types of the basic operators
	//////////////////////////////////////////////////////////////////////

	// Q15 sample word
	typedef logic signed [15:0] word16T;

	// Q31 accumulator word
	typedef logic signed [31:0] word32T;

	//////////////////////////////////////////////////////////////////////
	// Saturation limits
	//////////////////////////////////////////////////////////////////////

	// 16-bit range of add, sub, shl and shr
	localparam word16T MAX16 = 16'sh7fff;
	localparam word16T MIN16 = 16'sh8000;

	// 32-bit range of L_add, L_sub, L_mult and L_mac
	localparam word32T MAX32 = 32'sh7fff_ffff;
	localparam word32T MIN32 = 32'sh8000_0000;

endpackage
